/* Makefile */
# Verilator build and run for the FM phase generator

VERILATOR  ?= verilator
TOP        := fm_pg_tb
FLIST      := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Pass or fail comes from the log
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Test run did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+.
fm_pg_pkg.sv
slot_shreg.sv
pg_freq.sv
pg_lfo_pm.sv
pg_accum.sv
fm_pg.sv
fm_pg_tb.sv

/* fm_pg.sv */
`timescale 1ns/1ps

module fm_pg #(
	parameter int SLOTS      = 24,
	parameter int OUT_STAGES = 6
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cen,
	// Stage I, current slot
	input  fm_pg_pkg::fnum_t    fnum,
	input  fm_pg_pkg::block_t   block,
	input  logic [2:0]          dt,
	input  logic [6:0]          lfo_mod,
	input  logic [2:0]          pms,
	// Stage II, previous slot
	input  logic [3:0]          mul,
	input  logic                pg_rst,
	output fm_pg_pkg::keycode_t keycode,
	output fm_pg_pkg::phout_t   phase_out
);

	fm_pg_pkg::detune_t detune;
	fm_pg_pkg::inc_t    base_inc;
	fm_pg_pkg::pm_t     pm_off;

	// Keycode, detune and base increment
	pg_freq freq_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.cen      (cen),
		.fnum     (fnum),
		.block    (block),
		.dt       (dt),
		.keycode  (keycode),
		.detune   (detune),
		.base_inc (base_inc)
	);

	// LFO phase offset, same stage as the frequency path
	pg_lfo_pm lfo_pm_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.cen     (cen),
		.fnum    (fnum),
		.block   (block),
		.lfo_mod (lfo_mod),
		.pms     (pms),
		.pm_off  (pm_off)
	);

	pg_accum #(
		.SLOTS      (SLOTS),
		.OUT_STAGES (OUT_STAGES)
	) accum_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cen       (cen),
		.base_inc  (base_inc),
		.pm_off    (pm_off),
		.detune    (detune),
		.mul       (mul),
		.pg_rst    (pg_rst),
		.phase_out (phase_out)
	);

endmodule

/* fm_pg_pkg.sv */
package fm_pg_pkg;

	// Channel frequency fields
	localparam int FNUM_W  = 11;
	localparam int BLOCK_W = 3;
	// Keycode is block plus a 2-bit note
	localparam int KC_W    = 5;
	// Increment before the multiplier
	localparam int INC_W   = 17;
	// Accumulator and the slice sent to the operator
	localparam int PHASE_W = 20;
	localparam int PHOUT_W = 10;

	typedef logic [FNUM_W-1:0]  fnum_t;
	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [KC_W-1:0]    keycode_t;
	typedef logic [INC_W-1:0]   inc_t;
	typedef logic [PHASE_W-1:0] phase_t;
	typedef logic [PHOUT_W-1:0] phout_t;

	// Detune in increment units, sign from dt[2]
	typedef logic signed [5:0]  detune_t;
	// LFO phase offset in increment units
	typedef logic signed [11:0] pm_t;

	// Detune magnitudes
	// Row is the keycode, column is dt[1:0]; column 0 means no detune
	localparam logic [4:0] dt_table [0:31][0:3] = '{
		'{5'd0, 5'd0, 5'd1, 5'd2},
		'{5'd0, 5'd0, 5'd1, 5'd2},
		'{5'd0, 5'd0, 5'd1, 5'd2},
		'{5'd0, 5'd0, 5'd1, 5'd2},
		'{5'd0, 5'd1, 5'd2, 5'd2},
		'{5'd0, 5'd1, 5'd2, 5'd3},
		'{5'd0, 5'd1, 5'd2, 5'd3},
		'{5'd0, 5'd1, 5'd2, 5'd3},
		// Block 2
		'{5'd0, 5'd1, 5'd2, 5'd4},
		'{5'd0, 5'd1, 5'd3, 5'd4},
		'{5'd0, 5'd1, 5'd3, 5'd4},
		'{5'd0, 5'd1, 5'd3, 5'd5},
		'{5'd0, 5'd2, 5'd4, 5'd5},
		'{5'd0, 5'd2, 5'd4, 5'd6},
		'{5'd0, 5'd2, 5'd4, 5'd6},
		'{5'd0, 5'd2, 5'd5, 5'd7},
		// Block 4
		'{5'd0, 5'd2, 5'd5, 5'd8},
		'{5'd0, 5'd3, 5'd6, 5'd8},
		'{5'd0, 5'd3, 5'd6, 5'd9},
		'{5'd0, 5'd3, 5'd7, 5'd10},
		'{5'd0, 5'd4, 5'd8, 5'd11},
		'{5'd0, 5'd4, 5'd8, 5'd12},
		'{5'd0, 5'd4, 5'd9, 5'd13},
		'{5'd0, 5'd5, 5'd10, 5'd14},
		// Block 6 and up, top rows saturate
		'{5'd0, 5'd5, 5'd11, 5'd16},
		'{5'd0, 5'd6, 5'd12, 5'd17},
		'{5'd0, 5'd6, 5'd13, 5'd19},
		'{5'd0, 5'd7, 5'd14, 5'd20},
		'{5'd0, 5'd8, 5'd16, 5'd22},
		'{5'd0, 5'd8, 5'd16, 5'd22},
		'{5'd0, 5'd8, 5'd16, 5'd22},
		'{5'd0, 5'd8, 5'd16, 5'd22}
	};

endpackage

/* fm_pg_tb_vectors.svh */
`ifndef FM_PG_TB_VECTORS_SVH
`define FM_PG_TB_VECTORS_SVH

// Columns: slot, fnum, block, dt, lfo_mod, pms, mul, pg_rst, cen, rounds, expected keycode
// Slots other than the row's slot get random fill each round
localparam int NUM_ROWS = 27;

localparam vec_t vectors [NUM_ROWS] = '{
	// Note boundaries of fnum bits 9..7 at several blocks
	'{5'd3,  11'h37F, 3'd0, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b1, 8'd1, 5'd0},
	'{5'd4,  11'h380, 3'd1, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b1, 8'd1, 5'd5},
	'{5'd5,  11'h3FF, 3'd2, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b1, 8'd1, 5'd9},
	'{5'd6,  11'h400, 3'd3, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b1, 8'd1, 5'd14},
	'{5'd7,  11'h47F, 3'd5, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b1, 8'd1, 5'd22},
	'{5'd8,  11'h480, 3'd7, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b1, 8'd1, 5'd31},
	'{5'd9,  11'h7FF, 3'd4, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b1, 8'd1, 5'd19},
	'{5'd10, 11'h000, 3'd6, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b1, 8'd1, 5'd24},
	// Plain accumulation, mul 0 is half, mul 15 wraps every round
	'{5'd0,  11'h2A5, 3'd4, 3'd0, 7'h00, 3'd0, 4'd0,  1'b0, 1'b1, 8'd3, 5'd16},
	'{5'd0,  11'h2A5, 3'd4, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b1, 8'd3, 5'd16},
	'{5'd1,  11'h7FF, 3'd7, 3'd0, 7'h00, 3'd0, 4'd15, 1'b0, 1'b1, 8'd3, 5'd31},
	// Detune up
	'{5'd2,  11'h500, 3'd5, 3'd1, 7'h00, 3'd0, 4'd2,  1'b0, 1'b1, 8'd1, 5'd23},
	'{5'd2,  11'h500, 3'd5, 3'd2, 7'h00, 3'd0, 4'd2,  1'b0, 1'b1, 8'd1, 5'd23},
	'{5'd2,  11'h500, 3'd5, 3'd3, 7'h00, 3'd0, 4'd2,  1'b0, 1'b1, 8'd2, 5'd23},
	// Detune down
	'{5'd2,  11'h500, 3'd5, 3'd5, 7'h00, 3'd0, 4'd2,  1'b0, 1'b1, 8'd1, 5'd23},
	'{5'd2,  11'h500, 3'd5, 3'd6, 7'h00, 3'd0, 4'd2,  1'b0, 1'b1, 8'd1, 5'd23},
	'{5'd2,  11'h500, 3'd5, 3'd7, 7'h00, 3'd0, 4'd2,  1'b0, 1'b1, 8'd1, 5'd23},
	// Neutral codes
	'{5'd2,  11'h500, 3'd5, 3'd0, 7'h00, 3'd0, 4'd2,  1'b0, 1'b1, 8'd1, 5'd23},
	'{5'd2,  11'h500, 3'd5, 3'd4, 7'h00, 3'd0, 4'd2,  1'b0, 1'b1, 8'd1, 5'd23},
	// PM off, then both LFO signs
	'{5'd11, 11'h6C0, 3'd6, 3'd0, 7'h3C, 3'd0, 4'd1,  1'b0, 1'b1, 8'd1, 5'd27},
	'{5'd11, 11'h6C0, 3'd6, 3'd0, 7'h3C, 3'd3, 4'd1,  1'b0, 1'b1, 8'd2, 5'd27},
	'{5'd11, 11'h6C0, 3'd6, 3'd0, 7'h3C, 3'd7, 4'd1,  1'b0, 1'b1, 8'd1, 5'd27},
	'{5'd11, 11'h6C0, 3'd6, 3'd0, 7'h7C, 3'd5, 4'd1,  1'b0, 1'b1, 8'd1, 5'd27},
	'{5'd11, 11'h6C0, 3'd6, 3'd0, 7'h54, 3'd1, 4'd1,  1'b0, 1'b1, 8'd1, 5'd27},
	// Restart one slot, freeze a round, then resume
	'{5'd0,  11'h2A5, 3'd4, 3'd0, 7'h00, 3'd0, 4'd1,  1'b1, 1'b1, 8'd2, 5'd16},
	'{5'd0,  11'h2A5, 3'd4, 3'd0, 7'h00, 3'd0, 4'd1,  1'b0, 1'b0, 8'd1, 5'd0},
	'{5'd0,  11'h2A5, 3'd4, 3'd0, 7'h00, 3'd0, 4'd3,  1'b0, 1'b1, 8'd2, 5'd16}
};

`endif

/* fm_pg_tb.sv */
`timescale 1ns/1ps

module fm_pg_tb;

	localparam int SLOTS      = 24;
	localparam int OUT_STAGES = 6;
	localparam int RST_CYCLES = 5;

	// One test step
	typedef struct packed {
		logic [4:0]  slot;
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  dt;
		logic [6:0]  lfo_mod;
		logic [2:0]  pms;
		logic [3:0]  mul;
		logic        pg_rst;
		logic        cen;
		logic [7:0]  rounds;
		logic [4:0]  kc;
	} vec_t;

	`include "fm_pg_tb_vectors.svh"

	logic                clk;
	logic                rst_n;
	logic                cen;
	fm_pg_pkg::fnum_t    fnum;
	fm_pg_pkg::block_t   block;
	logic [2:0]          dt;
	logic [6:0]          lfo_mod;
	logic [2:0]          pms;
	logic [3:0]          mul;
	logic                pg_rst;
	fm_pg_pkg::keycode_t keycode;
	fm_pg_pkg::phout_t   phase_out;

	// Settings each slot was last presented with
	logic [10:0] cfg_fnum [SLOTS];
	logic [2:0]  cfg_block [SLOTS];
	logic [2:0]  cfg_dt [SLOTS];
	logic [6:0]  cfg_lfo [SLOTS];
	logic [2:0]  cfg_pms [SLOTS];
	logic [3:0]  cfg_mul [SLOTS];
	logic        cfg_rst [SLOTS];
	// Reference phase per slot
	int          model_phase [SLOTS];
	// Expected phase_out per enabled edge
	int          exp_q [$];

	int          errors;
	int          cycles;
	int          limit;
	int          prev_slot;
	logic        en_prev;
	int          kc_prev;
	logic [4:0]  kc_hold;
	logic [9:0]  ph_hold;

	fm_pg fm_pg_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cen       (cen),
		.fnum      (fnum),
		.block     (block),
		.dt        (dt),
		.lfo_mod   (lfo_mod),
		.pms       (pms),
		.mul       (mul),
		.pg_rst    (pg_rst),
		.keycode   (keycode),
		.phase_out (phase_out)
	);

	always #20 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout: no end of test after %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// Octave times four plus the note from fnum's top nibble
	function automatic int kc_model(logic [10:0] f, logic [2:0] b);
		int top;
		int note;
		top = int'(f[10:7]);
		note = (top >= 8) ? 2 : 0;
		if (top == 7 || top >= 9) begin
			note = note + 1;
		end
		return int'(b) * 4 + note;
	endfunction

	// Increment after detune, PM and multiplier
	function automatic int scaled_inc(int slot);
		int base;
		int det;
		int mag;
		int pm;
		int sum;
		base = (int'(cfg_fnum[slot]) * (1 << cfg_block[slot])) / 2;
		det = int'(fm_pg_pkg::dt_table[kc_model(cfg_fnum[slot], cfg_block[slot])]
			[cfg_dt[slot][1:0]]);
		if (cfg_dt[slot][2]) begin
			det = -det;
		end
		pm = 0;
		if (cfg_pms[slot] != 3'd0) begin
			mag = int'(cfg_lfo[slot][5:2]);
			pm = (mag * int'(cfg_fnum[slot][10:4])) * (1 << cfg_block[slot]);
			pm = (pm >> (9 - int'(cfg_pms[slot]))) % 4096;
			if (cfg_lfo[slot][6]) begin
				pm = (4096 - pm) % 4096;
			end
			// Back to a signed 12-bit offset
			if (pm >= 2048) begin
				pm = pm - 4096;
			end
		end
		sum = (base + pm + det) & 32'h1FFFF;
		if (cfg_mul[slot] == 4'd0) begin
			return sum >> 1;
		end
		return (sum * int'(cfg_mul[slot])) & 32'hFFFFF;
	endfunction

	// Drive for the next edge, then check the edge just taken
	task automatic run_cycle(input logic en, input int s, input logic use_row,
		input vec_t row);
		logic [31:0] rnd;
		int          kc_now;
		int          exp_ph;
		kc_now = 0;
		@(posedge clk);
		cen <= en;
		if (en) begin
			if (use_row) begin
				cfg_fnum[s] = row.fnum;
				cfg_block[s] = row.block;
				cfg_dt[s] = row.dt;
				cfg_lfo[s] = row.lfo_mod;
				cfg_pms[s] = row.pms;
				cfg_mul[s] = row.mul;
				cfg_rst[s] = row.pg_rst;
				kc_now = int'(row.kc);
			end else begin
				// Idle slot gets all fields from one random word
				rnd = $urandom();
				cfg_fnum[s] = rnd[10:0];
				cfg_block[s] = rnd[13:11];
				cfg_dt[s] = rnd[16:14];
				cfg_lfo[s] = rnd[23:17];
				cfg_pms[s] = rnd[26:24];
				cfg_mul[s] = rnd[30:27];
				cfg_rst[s] = 1'b0;
				kc_now = kc_model(cfg_fnum[s], cfg_block[s]);
			end
			fnum <= cfg_fnum[s];
			block <= cfg_block[s];
			dt <= cfg_dt[s];
			lfo_mod <= cfg_lfo[s];
			pms <= cfg_pms[s];
			// Previous slot is in stage II
			mul <= cfg_mul[prev_slot];
			pg_rst <= cfg_rst[prev_slot];
			if (cfg_rst[prev_slot]) begin
				model_phase[prev_slot] = 0;
			end else begin
				model_phase[prev_slot] = (model_phase[prev_slot] + scaled_inc(prev_slot))
					& 32'hFFFFF;
			end
			exp_q.push_back(model_phase[prev_slot] >> 10);
			prev_slot = s;
		end else begin
			// Inputs keep moving while the engine is frozen
			rnd = $urandom();
			fnum <= rnd[10:0];
			block <= rnd[13:11];
			dt <= rnd[16:14];
			lfo_mod <= rnd[23:17];
			pms <= rnd[26:24];
			mul <= rnd[30:27];
			pg_rst <= rnd[31];
		end
		@(negedge clk);
		if (en_prev) begin
			exp_ph = exp_q.pop_front();
			assert (int'(keycode) == kc_prev) else begin
				$display("CHECK FAILED at %0t: keycode %0d, expected %0d",
					$time, keycode, kc_prev);
				errors++;
			end
			assert (int'(phase_out) == exp_ph) else begin
				$display("CHECK FAILED at %0t: phase_out %0d, expected %0d",
					$time, phase_out, exp_ph);
				errors++;
			end
		end else begin
			// Outputs hold over a frozen edge
			assert (keycode == kc_hold && phase_out == ph_hold) else begin
				$display("CHECK FAILED at %0t: outputs moved on a disabled edge (%0d, %0d)",
					$time, keycode, phase_out);
				errors++;
			end
		end
		kc_hold = keycode;
		ph_hold = phase_out;
		en_prev = en;
		kc_prev = kc_now;
	endtask

	initial begin
		int total;
		void'($urandom(32'hda09));
		clk = 1'b0;
		rst_n = 1'b0;
		cen = 1'b0;
		fnum = '0;
		block = '0;
		dt = '0;
		lfo_mod = '0;
		pms = '0;
		mul = '0;
		pg_rst = 1'b0;
		errors = 0;
		cycles = 0;
		prev_slot = SLOTS - 1;
		en_prev = 1'b0;
		kc_prev = 0;
		kc_hold = '0;
		ph_hold = '0;
		for (int i = 0; i < SLOTS; i++) begin
			cfg_fnum[i] = '0;
			cfg_block[i] = '0;
			cfg_dt[i] = '0;
			cfg_lfo[i] = '0;
			cfg_pms[i] = '0;
			cfg_mul[i] = '0;
			cfg_rst[i] = 1'b0;
			model_phase[i] = 0;
		end
		// Pad is empty for the first OUT_STAGES enabled edges
		for (int i = 0; i < OUT_STAGES; i++) begin
			exp_q.push_back(0);
		end
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			total = total + int'(vectors[r].rounds) * SLOTS;
		end
		limit = total + RST_CYCLES + OUT_STAGES + 50;

		repeat (RST_CYCLES) @(posedge clk);
		assert (keycode == '0 && phase_out == '0) else begin
			$display("CHECK FAILED at %0t: outputs not zero in reset", $time);
			errors++;
		end
		rst_n <= 1'b1;

		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int k = 0; k < int'(vectors[r].rounds) * SLOTS; k++) begin
				run_cycle(vectors[r].cen, k % SLOTS, (k % SLOTS) == int'(vectors[r].slot),
					vectors[r]);
			end
		end
		// Flush the pad with idle slots
		for (int k = 0; k < OUT_STAGES; k++) begin
			run_cycle(1'b1, k, 1'b0, vectors[0]);
		end

		$display("Run complete, %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* pg_accum.sv */
`timescale 1ns/1ps

module pg_accum #(
	parameter int SLOTS      = 24,
	parameter int OUT_STAGES = 6
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cen,
	input  fm_pg_pkg::inc_t     base_inc,
	input  fm_pg_pkg::pm_t      pm_off,
	input  fm_pg_pkg::detune_t  detune,
	input  logic [3:0]          mul,
	input  logic                pg_rst,
	output fm_pg_pkg::phout_t   phase_out
);

	logic signed [fm_pg_pkg::INC_W+1:0] sum_w;
	fm_pg_pkg::inc_t                    inc_sum;
	logic [fm_pg_pkg::INC_W+3:0]        inc_prod;
	fm_pg_pkg::phase_t                  inc_scaled;
	fm_pg_pkg::phase_t                  phase_old;
	fm_pg_pkg::phase_t                  phase_new;
	fm_pg_pkg::phout_t                  phout_q;

	// All three terms sign-extended, then wrapped back to 17 bits
	assign sum_w   = $signed({2'b00, base_inc}) + pm_off + detune;
	assign inc_sum = sum_w[fm_pg_pkg::INC_W-1:0];

	// Multiplier 1..15
	assign inc_prod = {4'b0, inc_sum} * {{(fm_pg_pkg::INC_W){1'b0}}, mul};

	// Multiplier 0 means one half
	always_comb begin
		if (mul == 4'd0) begin
			inc_scaled = {{(fm_pg_pkg::PHASE_W - fm_pg_pkg::INC_W + 1){1'b0}},
				inc_sum[fm_pg_pkg::INC_W-1:1]};
		end else begin
			inc_scaled = inc_prod[fm_pg_pkg::PHASE_W-1:0];
		end
	end

	// Stage II accumulate, key-on restart wins
	assign phase_new = pg_rst ? '0 : phase_old + inc_scaled;

	// One slot-wide ring of phases
	slot_shreg #(
		.T      (fm_pg_pkg::phase_t),
		.STAGES (SLOTS)
	) ring_i (
		.clk   (clk),
		.rst_n (rst_n),
		.cen   (cen),
		.din   (phase_new),
		.drop  (phase_old)
	);

	// Top bits leave stage II here
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phout_q <= '0;
		end else if (cen) begin
			phout_q <= phase_new[fm_pg_pkg::PHASE_W-1 -: fm_pg_pkg::PHOUT_W];
		end
	end

	// Delay to meet the operator pipeline
	slot_shreg #(
		.T      (fm_pg_pkg::phout_t),
		.STAGES (OUT_STAGES)
	) pad_i (
		.clk   (clk),
		.rst_n (rst_n),
		.cen   (cen),
		.din   (phout_q),
		.drop  (phase_out)
	);

	// Restarted slot lands as zero at the head of the ring
	assert property (@(posedge clk) disable iff (!rst_n)
		cen && pg_rst |=> ring_i.sr[0] == '0);

endmodule

/* pg_freq.sv */
`timescale 1ns/1ps

module pg_freq (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cen,
	input  fm_pg_pkg::fnum_t    fnum,
	input  fm_pg_pkg::block_t   block,
	input  logic [2:0]          dt,
	output fm_pg_pkg::keycode_t keycode,
	output fm_pg_pkg::detune_t  detune,
	output fm_pg_pkg::inc_t     base_inc
);

	logic                        note_lo;
	fm_pg_pkg::keycode_t         keycode_c;
	logic [4:0]                  dt_mag;
	fm_pg_pkg::detune_t          detune_c;
	logic [fm_pg_pkg::INC_W:0]   inc_shl;
	fm_pg_pkg::inc_t             base_inc_c;

	// Note low bit
	// Upper half of the octave needs any of 9..7, lower half needs all of them
	always_comb begin
		if (fnum[10]) begin
			note_lo = |fnum[9:7];
		end else begin
			note_lo = &fnum[9:7];
		end
	end

	// Block times four plus note
	assign keycode_c = {block, fnum[10], note_lo};

	// Detune magnitude from the keycode row
	assign dt_mag = fm_pg_pkg::dt_table[keycode_c][dt[1:0]];

	// dt[2] selects the downward direction
	assign detune_c = dt[2] ? -$signed({1'b0, dt_mag}) : $signed({1'b0, dt_mag});

	// Octave shift, one bit wider so the final halving keeps all 17 bits
	assign inc_shl = {{(fm_pg_pkg::INC_W + 1 - fm_pg_pkg::FNUM_W){1'b0}}, fnum} << block;
	assign base_inc_c = inc_shl[fm_pg_pkg::INC_W:1];

	// Stage I to stage II
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			keycode  <= '0;
			detune   <= '0;
			base_inc <= '0;
		end else if (cen) begin
			keycode  <= keycode_c;
			detune   <= detune_c;
			base_inc <= base_inc_c;
		end
	end

	// Stage II keycode still carries the block seen in stage I
	assert property (@(posedge clk) disable iff (!rst_n)
		cen |=> keycode[fm_pg_pkg::KC_W-1 -: fm_pg_pkg::BLOCK_W] == $past(block));

endmodule

/* pg_lfo_pm.sv */
`timescale 1ns/1ps

module pg_lfo_pm (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cen,
	input  fm_pg_pkg::fnum_t  fnum,
	input  fm_pg_pkg::block_t block,
	input  logic [6:0]        lfo_mod,
	input  logic [2:0]        pms,
	output fm_pg_pkg::pm_t    pm_off
);

	logic [3:0]     pm_depth;
	logic [10:0]    pm_prod;
	logic [17:0]    pm_shl;
	logic [17:0]    pm_mag;
	fm_pg_pkg::pm_t pm_c;

	// LFO depth without the sign bit
	assign pm_depth = lfo_mod[5:2];

	// Depth scaled by the top seven fnum bits
	assign pm_prod = {7'b0, pm_depth} * {4'b0, fnum[10:4]};

	// Octave shift, then PMS sets the final scale
	assign pm_shl = {7'b0, pm_prod} << block;
	assign pm_mag = pm_shl >> (4'd9 - {1'b0, pms});

	// Offset wraps to the 12-bit field
	always_comb begin
		if (pms == 3'd0) begin
			pm_c = '0;
		end else if (lfo_mod[6]) begin
			pm_c = -$signed(pm_mag[11:0]);
		end else begin
			pm_c = $signed(pm_mag[11:0]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pm_off <= '0;
		end else if (cen) begin
			pm_off <= pm_c;
		end
	end

	// PMS off means no offset in stage II
	assert property (@(posedge clk) disable iff (!rst_n)
		cen && pms == 3'd0 |=> pm_off == '0);

endmodule

/* slot_shreg.sv */
`timescale 1ns/1ps

module slot_shreg #(
	parameter type T      = logic,
	parameter int  STAGES = 1
) (
	input  logic clk,
	input  logic rst_n,
	input  logic cen,
	input  T     din,
	output T     drop
);

	// Entry 0 takes din, the last entry is the oldest
	T sr [STAGES];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				sr[i] <= '0;
			end
		end else if (cen) begin
			sr[0] <= din;
			for (int i = 1; i < STAGES; i++) begin
				sr[i] <= sr[i-1];
			end
		end
	end

	assign drop = sr[STAGES-1];

	generate
		if (STAGES == 1) begin : g_single
			// Single stage is a plain enabled register
			assert property (@(posedge clk) disable iff (!rst_n)
				cen |=> drop == $past(din));
		end else begin : g_multi
			// Whole line is empty during reset
			assert property (@(posedge clk) !rst_n |-> drop == '0);
		end
	endgenerate

endmodule
